// File: src/mips_pkg.sv
package mips_pkg;

  // ------------------------------------------------------------------
  // Widths and fixed addresses
  // ------------------------------------------------------------------
  localparam int word_w     = 32;
  localparam int reg_addr_w = 5;
  localparam int reg_count  = 32;

  typedef logic [word_w-1:0]     word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // First fetch address and byte distance between instructions
  localparam word_t reset_pc = '0;
  localparam word_t pc_step  = 32'd4;

  // ------------------------------------------------------------------
  // Instruction encodings
  // ------------------------------------------------------------------
  // Primary opcode, instr[31:26]
  typedef enum logic [5:0] {
    op_rtype = 6'b000000,
    op_beq   = 6'b000100,
    op_addi  = 6'b001000,
    op_addiu = 6'b001001,
    op_ori   = 6'b001101,
    op_lw    = 6'b100011,
    op_sw    = 6'b101011
  } opcode_e;

  // R-type function field, instr[5:0]
  typedef enum logic [5:0] {
    fn_add  = 6'b100000,
    fn_addu = 6'b100001,
    fn_sub  = 6'b100010,
    fn_subu = 6'b100011,
    fn_and  = 6'b100100,
    fn_or   = 6'b100101,
    fn_slt  = 6'b101010
  } funct_e;

  // ALU class chosen by the main decoder
  typedef enum logic [1:0] {
    alu_add   = 2'b00,
    alu_sub   = 2'b01,
    alu_or    = 2'b10,
    alu_funct = 2'b11
  } alu_op_e;

  // ALU operation select
  typedef enum logic [3:0] {
    alu_ctl_and = 4'b0000,
    alu_ctl_or  = 4'b0001,
    alu_ctl_add = 4'b0010,
    alu_ctl_sub = 4'b0110,
    alu_ctl_slt = 4'b0111
  } alu_ctl_e;

  // Source of an execute operand
  typedef enum logic [1:0] {
    fwd_none = 2'b00,
    fwd_mem  = 2'b01,
    fwd_wb   = 2'b10
  } fwd_sel_e;

endpackage

// File: src/reg_file.sv
`timescale 1ns/1ps

module reg_file import mips_pkg::*; (
  input  logic      clk,
  input  logic      we,
  input  reg_addr_t ra1,
  input  reg_addr_t ra2,
  input  reg_addr_t wa,
  input  word_t     wd,
  output word_t     rd1,
  output word_t     rd2
);

  word_t regs [reg_count];

  // Register zero is never written
  always_ff @(posedge clk) begin
    if (we && (wa != '0)) begin
      regs[wa] <= wd;
    end
  end

  // Same-cycle write is passed through to the reader
  assign rd1 = (ra1 == '0)             ? '0 :
               (we && (wa == ra1))     ? wd : regs[ra1];
  assign rd2 = (ra2 == '0)             ? '0 :
               (we && (wa == ra2))     ? wd : regs[ra2];

endmodule

// File: src/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import mips_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  stall,
  input  logic  branch_taken,
  input  word_t branch_target,
  input  word_t instr,
  output word_t pc,
  output word_t if_instr,
  output word_t if_pc_plus
);

  word_t pc_plus;

  // Address of the next sequential instruction
  assign pc_plus = pc + pc_step;

  // ------------------------------------------------------------------
  // Program counter and fetch/decode register
  // ------------------------------------------------------------------
  // Squash has priority over the load-use hold
  always_ff @(posedge clk) begin
    if (reset) begin
      pc       <= reset_pc;
      if_instr <= '0;
    end else if (branch_taken) begin
      pc       <= branch_target;
      // All-zero word decodes to nothing written anywhere
      if_instr <= '0;
    end else if (!stall) begin
      pc       <= pc_plus;
      if_instr <= instr;
    end
  end

  // Link address travels with the instruction, held on stall
  always_ff @(posedge clk) begin
    if (!stall) begin
      if_pc_plus <= pc_plus;
    end
  end

endmodule

// File: src/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import mips_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  word_t      if_instr,
  input  word_t      if_pc_plus,
  input  logic       branch_taken,
  input  logic       wb_reg_write,
  input  reg_addr_t  wb_dest,
  input  word_t      wb_value,
  output logic       stall,
  output alu_op_e    ex_alu_op,
  output logic       ex_alu_src,
  output logic       ex_reg_dst,
  output logic       ex_branch,
  output logic       ex_mem_read,
  output logic       ex_mem_write,
  output logic       ex_mem_to_reg,
  output logic       ex_reg_write,
  output word_t      ex_rs_val,
  output word_t      ex_rt_val,
  output word_t      ex_imm,
  output reg_addr_t  ex_rs,
  output reg_addr_t  ex_rt,
  output reg_addr_t  ex_rd,
  output logic [5:0] ex_funct,
  output word_t      ex_pc_plus
);

  // Instruction fields
  opcode_e   opcode;
  reg_addr_t rs;
  reg_addr_t rt;
  reg_addr_t rd;
  word_t     rs_val;
  word_t     rt_val;
  word_t     imm;

  assign opcode = opcode_e'(if_instr[31:26]);
  assign rs     = if_instr[25:21];
  assign rt     = if_instr[20:16];
  assign rd     = if_instr[15:11];

  // Decoded controls before the decode/execute register
  alu_op_e   dec_alu_op;
  logic      dec_alu_src;
  logic      dec_reg_dst;
  logic      dec_branch;
  logic      dec_mem_read;
  logic      dec_mem_write;
  logic      dec_mem_to_reg;
  logic      dec_writes;
  logic      dec_zero_ext;
  logic      dec_reg_write;
  reg_addr_t dec_dest;

  // ------------------------------------------------------------------
  // Main decoder
  // ------------------------------------------------------------------
  always_comb begin
    dec_alu_op     = alu_add;
    dec_alu_src    = 1'b0;
    dec_reg_dst    = 1'b0;
    dec_branch     = 1'b0;
    dec_mem_read   = 1'b0;
    dec_mem_write  = 1'b0;
    dec_mem_to_reg = 1'b0;
    dec_writes     = 1'b0;
    dec_zero_ext   = 1'b0;
    case (opcode)
      op_rtype: begin
        dec_alu_op  = alu_funct;
        dec_reg_dst = 1'b1;
        dec_writes  = 1'b1;
      end
      op_lw: begin
        dec_alu_src    = 1'b1;
        dec_mem_read   = 1'b1;
        dec_mem_to_reg = 1'b1;
        dec_writes     = 1'b1;
      end
      op_sw: begin
        dec_alu_src   = 1'b1;
        dec_mem_write = 1'b1;
      end
      // Equality checked by subtraction class
      op_beq: begin
        dec_alu_op = alu_sub;
        dec_branch = 1'b1;
      end
      op_addi, op_addiu: begin
        dec_alu_src = 1'b1;
        dec_writes  = 1'b1;
      end
      op_ori: begin
        dec_alu_op   = alu_or;
        dec_alu_src  = 1'b1;
        dec_writes   = 1'b1;
        dec_zero_ext = 1'b1;
      end
      // Unknown opcode is a no-op
      default: ;
    endcase
  end

  // A write aimed at register zero is dropped here, so later stages
  // never see a live write to it
  assign dec_dest      = dec_reg_dst ? rd : rt;
  assign dec_reg_write = dec_writes && (dec_dest != '0);

  // Zero extension only for ORI
  assign imm = dec_zero_ext ? {16'b0, if_instr[15:0]}
                            : {{16{if_instr[15]}}, if_instr[15:0]};

  // Load in execute feeding this instruction
  assign stall = ex_mem_read && ((ex_rt == rs) || (ex_rt == rt));

  reg_file u_regs (
    .clk (clk),
    .we  (wb_reg_write),
    .ra1 (rs),
    .ra2 (rt),
    .wa  (wb_dest),
    .wd  (wb_value),
    .rd1 (rs_val),
    .rd2 (rt_val)
  );

  // ------------------------------------------------------------------
  // Decode/execute register
  // ------------------------------------------------------------------
  // Bubble on stall or on a taken branch
  always_ff @(posedge clk) begin
    if (reset || stall || branch_taken) begin
      ex_alu_op     <= alu_add;
      ex_alu_src    <= 1'b0;
      ex_reg_dst    <= 1'b0;
      ex_branch     <= 1'b0;
      ex_mem_read   <= 1'b0;
      ex_mem_write  <= 1'b0;
      ex_mem_to_reg <= 1'b0;
      ex_reg_write  <= 1'b0;
    end else begin
      ex_alu_op     <= dec_alu_op;
      ex_alu_src    <= dec_alu_src;
      ex_reg_dst    <= dec_reg_dst;
      ex_branch     <= dec_branch;
      ex_mem_read   <= dec_mem_read;
      ex_mem_write  <= dec_mem_write;
      ex_mem_to_reg <= dec_mem_to_reg;
      ex_reg_write  <= dec_reg_write;
    end
  end

  // Operands and fields
  always_ff @(posedge clk) begin
    ex_rs_val  <= rs_val;
    ex_rt_val  <= rt_val;
    ex_imm     <= imm;
    ex_rs      <= rs;
    ex_rt      <= rt;
    ex_rd      <= rd;
    ex_funct   <= if_instr[5:0];
    ex_pc_plus <= if_pc_plus;
  end

endmodule

// File: src/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import mips_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  alu_op_e    ex_alu_op,
  input  logic       ex_alu_src,
  input  logic       ex_reg_dst,
  input  logic       ex_branch,
  input  logic       ex_mem_read,
  input  logic       ex_mem_write,
  input  logic       ex_mem_to_reg,
  input  logic       ex_reg_write,
  input  word_t      ex_rs_val,
  input  word_t      ex_rt_val,
  input  word_t      ex_imm,
  input  reg_addr_t  ex_rs,
  input  reg_addr_t  ex_rt,
  input  reg_addr_t  ex_rd,
  input  logic [5:0] ex_funct,
  input  word_t      ex_pc_plus,
  input  logic       wb_reg_write,
  input  reg_addr_t  wb_dest,
  input  word_t      wb_value,
  output logic       branch_taken,
  output word_t      branch_target,
  output logic       mem_reg_write,
  output logic       mem_mem_to_reg,
  output reg_addr_t  mem_dest,
  output word_t      mem_alu_out,
  output logic       mem_mem_write,
  output word_t      mem_store_data
);

  alu_ctl_e alu_ctl;
  fwd_sel_e fwd_a;
  fwd_sel_e fwd_b;
  word_t    src_a;
  word_t    src_b;
  word_t    alu_b;
  word_t    alu_out;

  // ------------------------------------------------------------------
  // Forwarding
  // ------------------------------------------------------------------
  // Younger result in the memory stage wins
  function automatic fwd_sel_e fwd_pick(input reg_addr_t src,
                                        input logic      m_we,
                                        input reg_addr_t m_dest,
                                        input logic      w_we,
                                        input reg_addr_t w_dest);
    if (src == '0) begin
      return fwd_none;
    end else if (m_we && (m_dest == src)) begin
      return fwd_mem;
    end else if (w_we && (w_dest == src)) begin
      return fwd_wb;
    end
    return fwd_none;
  endfunction

  function automatic word_t fwd_value(input fwd_sel_e sel, input word_t reg_val,
                                      input word_t m_val, input word_t w_val);
    case (sel)
      fwd_mem: return m_val;
      fwd_wb:  return w_val;
      default: return reg_val;
    endcase
  endfunction

  assign fwd_a = fwd_pick(ex_rs, mem_reg_write, mem_dest, wb_reg_write, wb_dest);
  assign fwd_b = fwd_pick(ex_rt, mem_reg_write, mem_dest, wb_reg_write, wb_dest);
  assign src_a = fwd_value(fwd_a, ex_rs_val, mem_alu_out, wb_value);
  assign src_b = fwd_value(fwd_b, ex_rt_val, mem_alu_out, wb_value);

  // ------------------------------------------------------------------
  // ALU
  // ------------------------------------------------------------------
  // Overflow traps are not modelled, so signed and unsigned add match
  always_comb begin
    case (ex_alu_op)
      alu_add: alu_ctl = alu_ctl_add;
      alu_sub: alu_ctl = alu_ctl_sub;
      alu_or:  alu_ctl = alu_ctl_or;
      default: begin
        case (ex_funct)
          fn_add, fn_addu: alu_ctl = alu_ctl_add;
          fn_sub, fn_subu: alu_ctl = alu_ctl_sub;
          fn_and:          alu_ctl = alu_ctl_and;
          fn_or:           alu_ctl = alu_ctl_or;
          fn_slt:          alu_ctl = alu_ctl_slt;
          default:         alu_ctl = alu_ctl_add;
        endcase
      end
    endcase
  end

  assign alu_b = ex_alu_src ? ex_imm : src_b;

  always_comb begin
    case (alu_ctl)
      alu_ctl_and: alu_out = src_a & alu_b;
      alu_ctl_or:  alu_out = src_a | alu_b;
      alu_ctl_sub: alu_out = src_a - alu_b;
      alu_ctl_slt: alu_out = {31'b0, $signed(src_a) < $signed(alu_b)};
      default:     alu_out = src_a + alu_b;
    endcase
  end

  // BEQ resolves here; target is the next address plus word offset
  assign branch_taken  = ex_branch && (src_a == src_b);
  assign branch_target = ex_pc_plus + {ex_imm[29:0], 2'b00};

  // ------------------------------------------------------------------
  // Execute/memory register
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      mem_reg_write  <= 1'b0;
      mem_mem_to_reg <= 1'b0;
      mem_mem_write  <= 1'b0;
    end else begin
      mem_reg_write  <= ex_reg_write;
      mem_mem_to_reg <= ex_mem_to_reg && ex_mem_read;
      mem_mem_write  <= ex_mem_write;
    end
  end

  // Store data taken after forwarding
  always_ff @(posedge clk) begin
    mem_dest       <= ex_reg_dst ? ex_rd : ex_rt;
    mem_alu_out    <= alu_out;
    mem_store_data <= src_b;
  end

endmodule

// File: src/result_stage.sv
`timescale 1ns/1ps

module result_stage import mips_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      mem_reg_write,
  input  logic      mem_mem_to_reg,
  input  reg_addr_t mem_dest,
  input  word_t     mem_alu_out,
  input  word_t     mem_read_data,
  output logic      wb_reg_write,
  output reg_addr_t wb_dest,
  output word_t     wb_value
);

  logic  wb_mem_to_reg;
  word_t wb_alu_out;
  word_t wb_read_data;

  // ------------------------------------------------------------------
  // Memory/writeback register
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_reg_write  <= 1'b0;
      wb_mem_to_reg <= 1'b0;
    end else begin
      wb_reg_write  <= mem_reg_write;
      wb_mem_to_reg <= mem_mem_to_reg;
    end
  end

  // Read data is combinational from the bench, captured at the edge
  always_ff @(posedge clk) begin
    wb_dest      <= mem_dest;
    wb_alu_out   <= mem_alu_out;
    wb_read_data <= mem_read_data;
  end

  // Loads write memory data, all others the ALU result
  assign wb_value = wb_mem_to_reg ? wb_read_data : wb_alu_out;

endmodule

// File: src/mips_core.sv
`timescale 1ns/1ps

module mips_core import mips_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  output word_t pc,
  input  word_t instr,
  output logic  mem_write,
  output word_t mem_addr,
  output word_t mem_write_data,
  input  word_t mem_read_data
);

  // Fetch to decode
  word_t     if_instr;
  word_t     if_pc_plus;
  logic      stall;

  // Branch redirect from execute
  logic      branch_taken;
  word_t     branch_target;

  // Decode/execute register
  alu_op_e   ex_alu_op;
  logic      ex_alu_src;
  logic      ex_reg_dst;
  logic      ex_branch;
  logic      ex_mem_read;
  logic      ex_mem_write;
  logic      ex_mem_to_reg;
  logic      ex_reg_write;
  word_t     ex_rs_val;
  word_t     ex_rt_val;
  word_t     ex_imm;
  reg_addr_t ex_rs;
  reg_addr_t ex_rt;
  reg_addr_t ex_rd;
  logic [5:0] ex_funct;
  word_t     ex_pc_plus;

  // Execute/memory register
  logic      mem_reg_write;
  logic      mem_mem_to_reg;
  reg_addr_t mem_dest;
  word_t     mem_alu_out;
  word_t     mem_store_data;

  // Writeback results
  logic      wb_reg_write;
  reg_addr_t wb_dest;
  word_t     wb_value;

  // ------------------------------------------------------------------
  // Pipeline stages
  // ------------------------------------------------------------------
  fetch_stage u_fetch (
    .clk           (clk),
    .reset         (reset),
    .stall         (stall),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .instr         (instr),
    .pc            (pc),
    .if_instr      (if_instr),
    .if_pc_plus    (if_pc_plus)
  );

  decode_stage u_decode (
    .clk           (clk),
    .reset         (reset),
    .if_instr      (if_instr),
    .if_pc_plus    (if_pc_plus),
    .branch_taken  (branch_taken),
    .wb_reg_write  (wb_reg_write),
    .wb_dest       (wb_dest),
    .wb_value      (wb_value),
    .stall         (stall),
    .ex_alu_op     (ex_alu_op),
    .ex_alu_src    (ex_alu_src),
    .ex_reg_dst    (ex_reg_dst),
    .ex_branch     (ex_branch),
    .ex_mem_read   (ex_mem_read),
    .ex_mem_write  (ex_mem_write),
    .ex_mem_to_reg (ex_mem_to_reg),
    .ex_reg_write  (ex_reg_write),
    .ex_rs_val     (ex_rs_val),
    .ex_rt_val     (ex_rt_val),
    .ex_imm        (ex_imm),
    .ex_rs         (ex_rs),
    .ex_rt         (ex_rt),
    .ex_rd         (ex_rd),
    .ex_funct      (ex_funct),
    .ex_pc_plus    (ex_pc_plus)
  );

  execute_stage u_execute (
    .clk            (clk),
    .reset          (reset),
    .ex_alu_op      (ex_alu_op),
    .ex_alu_src     (ex_alu_src),
    .ex_reg_dst     (ex_reg_dst),
    .ex_branch      (ex_branch),
    .ex_mem_read    (ex_mem_read),
    .ex_mem_write   (ex_mem_write),
    .ex_mem_to_reg  (ex_mem_to_reg),
    .ex_reg_write   (ex_reg_write),
    .ex_rs_val      (ex_rs_val),
    .ex_rt_val      (ex_rt_val),
    .ex_imm         (ex_imm),
    .ex_rs          (ex_rs),
    .ex_rt          (ex_rt),
    .ex_rd          (ex_rd),
    .ex_funct       (ex_funct),
    .ex_pc_plus     (ex_pc_plus),
    .wb_reg_write   (wb_reg_write),
    .wb_dest        (wb_dest),
    .wb_value       (wb_value),
    .branch_taken   (branch_taken),
    .branch_target  (branch_target),
    .mem_reg_write  (mem_reg_write),
    .mem_mem_to_reg (mem_mem_to_reg),
    .mem_dest       (mem_dest),
    .mem_alu_out    (mem_alu_out),
    .mem_mem_write  (mem_write),
    .mem_store_data (mem_store_data)
  );

  result_stage u_result (
    .clk            (clk),
    .reset          (reset),
    .mem_reg_write  (mem_reg_write),
    .mem_mem_to_reg (mem_mem_to_reg),
    .mem_dest       (mem_dest),
    .mem_alu_out    (mem_alu_out),
    .mem_read_data  (mem_read_data),
    .wb_reg_write   (wb_reg_write),
    .wb_dest        (wb_dest),
    .wb_value       (wb_value)
  );

  // Store port comes straight from the execute/memory register
  assign mem_addr       = mem_alu_out;
  assign mem_write_data = mem_store_data;

endmodule

// File: bench/mips_chk.sv
`timescale 1ns/1ps

module mips_chk import mips_pkg::*; (
  input logic clk,
  input logic reset,
  input logic stall,
  input logic branch_taken,
  input logic mem_write
);

  // Count of failed assertions, read by the testbench at the end
  int fail_count = 0;

  // ------------------------------------------------------------------
  // Pipeline control properties
  // ------------------------------------------------------------------
  // Load-use bubble is a single cycle
  stall_single: assert property (@(posedge clk) disable iff (reset) stall |=> !stall)
    else begin
      fail_count = fail_count + 1;
      $error("load-use stall held for two cycles");
    end

  // No store leaves the core right after reset
  store_after_reset: assert property (@(posedge clk) reset |=> !mem_write)
    else begin
      fail_count = fail_count + 1;
      $error("mem_write high in the cycle after reset");
    end

  // Squash clears the next branch, so a taken branch is a one-cycle pulse
  branch_single: assert property (@(posedge clk) disable iff (reset)
                                  branch_taken |=> !branch_taken)
    else begin
      fail_count = fail_count + 1;
      $error("branch_taken high for two cycles");
    end

endmodule

bind mips_core mips_chk pipe_chk (
  .clk          (clk),
  .reset        (reset),
  .stall        (stall),
  .branch_taken (branch_taken),
  .mem_write    (mem_write)
);

// File: bench/mips_tb.sv
`timescale 1ns/1ps

module mips_tb import mips_pkg::*; ();

  // Five short programs of well under 60 cycles each, with margin
  localparam int timeout_cycles = 600;

  logic  clk;
  logic  reset;
  word_t pc;
  word_t instr;
  logic  mem_write;
  word_t mem_addr;
  word_t mem_write_data;
  word_t mem_read_data;

  // Word-addressed memories, program under construction and store log
  word_t imem [256];
  word_t dmem [256];
  word_t prog [$];
  word_t st_addr [$];
  word_t st_data [$];
  word_t exp_addr [$];
  word_t exp_data [$];
  logic [31:0] rng = 32'hcbe2;
  int    cycles = 0;

  mips_core DUT (.*);

  // Zero-latency reads
  assign instr         = imem[pc[9:2]];
  assign mem_read_data = dmem[mem_addr[9:2]];

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Store performed and logged at the rising edge
  always @(posedge clk) begin
    if (!reset && mem_write) begin
      st_addr.push_back(mem_addr);
      st_data.push_back(mem_write_data);
      dmem[mem_addr[9:2]] = mem_write_data;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > timeout_cycles) begin
      $display("ERROR: run timed out after %0d cycles", timeout_cycles);
      abort_run();
    end
  end

  // A failed pipeline assertion ends the run at once
  always @(negedge clk) begin
    if (DUT.pipe_chk.fail_count != 0) begin
      $display("ERROR: %0d pipeline assertions failed", DUT.pipe_chk.fail_count);
      abort_run();
    end
  end

  // ------------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Assembly operand order rd, rs, rt
  function automatic word_t r_op(input funct_e fn, input int rd, input int rs, input int rt);
    return {op_rtype, 5'(rs), 5'(rt), 5'(rd), 5'b0, fn};
  endfunction

  function automatic word_t i_op(input opcode_e op, input int rs, input int rt,
                                 input logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
  endfunction

  // SW rt to a fixed address off register zero, with the value it must carry
  task automatic emit_store(input int rt, input logic [15:0] addr, input word_t data);
    prog.push_back(i_op(op_sw, 0, rt, addr));
    exp_addr.push_back({{16{addr[15]}}, addr});
    exp_data.push_back(data);
  endtask

  // Undefined opcode carrying its own word address, a no-op for the core
  task automatic clear_code();
    int i;
    for (i = 0; i < 256; i++) begin
      imem[i] = {6'h3f, 26'(i)};
    end
  endtask

  task automatic start_program();
    int i;
    @(negedge clk);
    reset = 1'b1;
    clear_code();
    for (i = 0; i < prog.size(); i++) begin
      imem[i] = prog[i];
    end
    prog.delete();
    st_addr.delete();
    st_data.delete();
    repeat (2) @(negedge clk);
    reset = 1'b0;
  endtask

  // ------------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------------
  task automatic abort_run();
    $display("TEST FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %08h expected %08h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  // Waits for the last expected store, then checks the log in order
  task automatic compare_stores();
    int i;
    while (st_addr.size() < exp_addr.size()) begin
      @(negedge clk);
    end
    for (i = 0; i < exp_addr.size(); i++) begin
      check_word($sformatf("mem_addr of store %0d", i), st_addr[i], exp_addr[i]);
      check_word($sformatf("mem_write_data of store %0d", i), st_data[i], exp_data[i]);
    end
    exp_addr.delete();
    exp_data.delete();
  endtask

  // ------------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------------
  task automatic reset_values();
    start_program();
    check_word("pc", pc, 32'h0000_0000);
    check_flag("mem_write", mem_write, 1'b0);
    @(negedge clk);
    check_word("pc", pc, 32'h0000_0004);
  endtask

  task automatic alu_functions();
    word_t va;
    word_t vb;
    rng = xorshift(rng);
    va = {16'h0, rng[15:0]};
    rng = xorshift(rng);
    vb = {16'h0, rng[15:0]};
    prog.push_back(i_op(op_ori, 0, 1, va[15:0]));
    prog.push_back(i_op(op_ori, 0, 2, vb[15:0]));
    prog.push_back(r_op(fn_add, 3, 1, 2));
    emit_store(3, 16'h0100, va + vb);
    prog.push_back(r_op(fn_sub, 4, 1, 2));
    emit_store(4, 16'h0104, va - vb);
    prog.push_back(r_op(fn_and, 5, 1, 2));
    emit_store(5, 16'h0108, va & vb);
    prog.push_back(r_op(fn_or, 6, 1, 2));
    emit_store(6, 16'h010c, va | vb);
    // Difference may be negative, so this is a signed compare
    prog.push_back(r_op(fn_slt, 7, 4, 1));
    emit_store(7, 16'h0110, ($signed(va - vb) < $signed(va)) ? 32'd1 : 32'd0);
    prog.push_back(i_op(op_addi, 1, 8, 16'hfffd));
    emit_store(8, 16'h0114, va - 32'd3);
    prog.push_back(i_op(op_ori, 1, 9, 16'h8421));
    emit_store(9, 16'h0118, va | 32'h0000_8421);
    start_program();
    compare_stores();
  endtask

  task automatic forwarding_paths();
    word_t va;
    word_t vb;
    rng = xorshift(rng);
    va = {16'h0, rng[15:0]};
    rng = xorshift(rng);
    vb = {16'h0, rng[15:0]};
    prog.push_back(i_op(op_ori, 0, 1, va[15:0]));
    prog.push_back(i_op(op_ori, 0, 2, vb[15:0]));
    // $2 from memory stage, $1 from writeback
    prog.push_back(r_op(fn_addu, 3, 1, 2));
    prog.push_back(r_op(fn_subu, 4, 3, 2));
    prog.push_back(r_op(fn_or, 5, 4, 3));
    emit_store(5, 16'h0140, va | (va + vb));
    prog.push_back(i_op(op_addiu, 5, 6, 16'h0010));
    emit_store(6, 16'h0144, (va | (va + vb)) + 32'd16);
    emit_store(4, 16'h0148, va);
    start_program();
    compare_stores();
  endtask

  task automatic load_use_stall();
    word_t v;
    rng = xorshift(rng);
    v = {16'h0, rng[15:0]};
    prog.push_back(i_op(op_ori, 0, 1, v[15:0]));
    emit_store(1, 16'h0180, v);
    prog.push_back(i_op(op_lw, 0, 2, 16'h0180));
    prog.push_back(r_op(fn_addu, 3, 2, 2));
    emit_store(3, 16'h0184, v + v);
    // Store of a just-loaded register also waits a cycle
    prog.push_back(i_op(op_lw, 0, 4, 16'h0180));
    emit_store(4, 16'h0188, v);
    start_program();
    compare_stores();
  endtask

  task automatic branch_squash();
    word_t va;
    rng = xorshift(rng);
    va = {16'h0, rng[15:0]};
    prog.push_back(i_op(op_ori, 0, 1, va[15:0]));
    prog.push_back(i_op(op_ori, 0, 2, va[15:0]));
    prog.push_back(i_op(op_ori, 0, 3, va[15:0] ^ 16'h0001));
    // Taken, lands past the two stores below
    prog.push_back(i_op(op_beq, 1, 2, 16'h0002));
    prog.push_back(i_op(op_sw, 0, 1, 16'h01c0));
    prog.push_back(i_op(op_sw, 0, 2, 16'h01c4));
    prog.push_back(i_op(op_beq, 1, 3, 16'h0002));
    emit_store(1, 16'h01c8, va);
    emit_store(3, 16'h01cc, va ^ 32'h0000_0001);
    start_program();
    compare_stores();
  endtask

  task automatic zero_register();
    logic [15:0] v;
    rng = xorshift(rng);
    v = rng[15:0] | 16'h0001;
    prog.push_back(i_op(op_ori, 0, 0, v));
    emit_store(0, 16'h0200, 32'h0);
    prog.push_back(i_op(op_ori, 0, 1, v));
    prog.push_back(r_op(fn_addu, 0, 1, 1));
    emit_store(0, 16'h0204, 32'h0);
    start_program();
    compare_stores();
  endtask

  initial begin
    int i;
    reset = 1'b1;
    clear_code();
    for (i = 0; i < 256; i++) begin
      dmem[i] = 32'hd0d0_0000 | 32'(i);
    end
    reset_values();
    alu_functions();
    forwarding_paths();
    load_use_stall();
    branch_squash();
    zero_register();
    if (DUT.pipe_chk.fail_count == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("ERROR: %0d pipeline assertions failed", DUT.pipe_chk.fail_count);
      abort_run();
    end
  end

endmodule

// File: files.f
src/mips_pkg.sv
src/reg_file.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/mips_core.sv
bench/mips_chk.sv
bench/mips_tb.sv

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module mips_tb

# Checker errors keep the run going so the bench prints its own verdict
./obj_dir/Vmips_tb +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q '^TEST PASS$' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
